/* common/buf_port_if.sv */
`timescale 1ns/1ps

interface buf_port_if;

  logic              req;
  logic              we;
  epu_pkg::buf_addr_t addr;
  epu_pkg::data_t    wdata;
  // valid one cycle after a read request
  epu_pkg::data_t    rdata;

  modport master (
    output req, we, addr, wdata,
    input  rdata
  );

  modport memory (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

/* common/epu_consts.svh */
`ifndef EPU_CONSTS_SVH
`define EPU_CONSTS_SVH

`define DATA_W 32
`define BUF_DEPTH 256
`define BUF_AW 8
`define AXI_AW 12

// register map above the buffer window
`define REG_CTRL 12'h400
`define REG_STATUS 12'h404
`define REG_RESULT 12'h408

// ctrl register fields
`define CTRL_START_BIT 0
`define CTRL_CNT_LSB 8

`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif

/* common/epu_pkg.sv */
`include "epu_consts.svh"

package epu_pkg;

  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`BUF_AW-1:0] buf_addr_t;
  typedef logic [`AXI_AW-1:0] axi_addr_t;
  typedef logic [`BUF_AW-1:0] count_t;
  typedef logic [1:0] resp_t;

  typedef enum logic [2:0] {
    SL_IDLE,
    SL_ADDR,
    SL_REG,
    SL_BUF,
    SL_BUF_DATA,
    SL_RESP
  } slave_state_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_HOST,
    ARB_ENGINE
  } arb_state_t;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_READ,
    ENG_ACCUM,
    ENG_WRITE,
    ENG_DONE
  } eng_state_t;

endpackage

/* compile.f */
+incdir+common
common/epu_pkg.sv
common/buf_port_if.sv
input_buffer/buffer_sram.sv
input_buffer/input_buffer.sv
source/axi_lite_slave.sv
source/accum_engine.sv
source/epu_top.sv
verification/epu_asserts.sv
verification/tb_epu_top.sv

/* input_buffer/buffer_sram.sv */
`timescale 1ns/1ps
`include "epu_consts.svh"

module buffer_sram (
  input logic        clk,
  buf_port_if.memory mem
);

  epu_pkg::data_t ram [`BUF_DEPTH];

  always_ff @(posedge clk) begin
    if (mem.req) begin
      if (mem.we) begin
        ram[mem.addr] <= mem.wdata;
      end else begin
        // one cycle read latency
        mem.rdata <= ram[mem.addr];
      end
    end
  end

endmodule

/* input_buffer/input_buffer.sv */
`timescale 1ns/1ps

module input_buffer (
  input  logic       clk,
  input  logic       rst,
  input  logic       eng_busy_i,
  buf_port_if.memory host_port,
  buf_port_if.memory eng_port,
  output logic       host_gnt_o
);

  epu_pkg::arb_state_t state_q;
  epu_pkg::arb_state_t state_d;
  logic                eng_gnt;
  logic                host_rd_q;
  logic                eng_rd_q;

  buf_port_if mem_port ();

  buffer_sram u_sram (
    .clk(clk),
    .mem(mem_port)
  );

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q   <= epu_pkg::ARB_IDLE;
      host_rd_q <= 1'b0;
      eng_rd_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      host_rd_q <= host_gnt_o;
      eng_rd_q  <= eng_gnt;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      epu_pkg::ARB_IDLE: begin
        if (eng_busy_i) begin
          state_d = epu_pkg::ARB_ENGINE;
        end else if (host_port.req) begin
          state_d = epu_pkg::ARB_HOST;
        end
      end
      // host gets a single cycle
      epu_pkg::ARB_HOST:   state_d = eng_busy_i ? epu_pkg::ARB_ENGINE : epu_pkg::ARB_IDLE;
      epu_pkg::ARB_ENGINE: if (!eng_busy_i) state_d = epu_pkg::ARB_IDLE;
      default:             state_d = epu_pkg::ARB_IDLE;
    endcase
  end

  // engine owns the RAM from its first busy cycle
  assign eng_gnt    = eng_busy_i || (state_q == epu_pkg::ARB_ENGINE);
  assign host_gnt_o = (state_q == epu_pkg::ARB_HOST);

  always_comb begin
    mem_port.req   = 1'b0;
    mem_port.we    = 1'b0;
    mem_port.addr  = '0;
    mem_port.wdata = '0;
    if (eng_gnt) begin
      mem_port.req   = eng_port.req;
      mem_port.we    = eng_port.we;
      mem_port.addr  = eng_port.addr;
      mem_port.wdata = eng_port.wdata;
    end else if (host_gnt_o) begin
      mem_port.req   = host_port.req;
      mem_port.we    = host_port.we;
      mem_port.addr  = host_port.addr;
      mem_port.wdata = host_port.wdata;
    end
  end

  // read data back to whoever owned the previous cycle
  assign host_port.rdata = host_rd_q ? mem_port.rdata : '0;
  assign eng_port.rdata  = eng_rd_q ? mem_port.rdata : '0;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the EPU testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_epu_top \
  -f compile.f -o sim_epu
./obj_dir/sim_epu | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* source/accum_engine.sv */
`timescale 1ns/1ps

module accum_engine (
  input  logic            clk,
  input  logic            rst,
  input  logic            start_i,
  input  epu_pkg::count_t count_i,
  output logic            busy_o,
  output logic            done_o,
  output epu_pkg::data_t  result_o,
  buf_port_if.master      eng_port
);

  epu_pkg::eng_state_t state_q;
  epu_pkg::count_t     cnt_q;
  epu_pkg::buf_addr_t  idx_q;
  epu_pkg::data_t      sum_q;
  logic                rd_pend_q;
  logic                can_start;

  assign can_start = (state_q == epu_pkg::ENG_IDLE) || (state_q == epu_pkg::ENG_DONE);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q   <= epu_pkg::ENG_IDLE;
      rd_pend_q <= 1'b0;
      result_o  <= '0;
    end else begin
      rd_pend_q <= (state_q == epu_pkg::ENG_READ);
      case (state_q)
        epu_pkg::ENG_IDLE, epu_pkg::ENG_DONE: begin
          // empty run goes straight to write-back
          if (start_i) begin
            state_q <= (count_i == '0) ? epu_pkg::ENG_WRITE : epu_pkg::ENG_READ;
          end
        end
        epu_pkg::ENG_READ: begin
          if (idx_q == cnt_q - 1'b1) begin
            state_q <= epu_pkg::ENG_ACCUM;
          end
        end
        epu_pkg::ENG_ACCUM: state_q <= epu_pkg::ENG_WRITE;
        epu_pkg::ENG_WRITE: begin
          result_o <= sum_q;
          state_q  <= epu_pkg::ENG_DONE;
        end
        default: state_q <= epu_pkg::ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (can_start) begin
      if (start_i) begin
        cnt_q <= count_i;
        idx_q <= '0;
        sum_q <= '0;
      end
    end else begin
      if (state_q == epu_pkg::ENG_READ) begin
        idx_q <= idx_q + 1'b1;
      end
      // add the word requested last cycle
      if (rd_pend_q) begin
        sum_q <= sum_q + eng_port.rdata;
      end
    end
  end

  assign busy_o = !can_start;
  assign done_o = (state_q == epu_pkg::ENG_DONE);

  assign eng_port.req   = (state_q == epu_pkg::ENG_READ) || (state_q == epu_pkg::ENG_WRITE);
  assign eng_port.we    = (state_q == epu_pkg::ENG_WRITE);
  assign eng_port.addr  = (state_q == epu_pkg::ENG_WRITE) ? cnt_q : idx_q;
  assign eng_port.wdata = sum_q;

endmodule

/* source/axi_lite_slave.sv */
`timescale 1ns/1ps
`include "epu_consts.svh"

module axi_lite_slave (
  input  logic               clk,
  input  logic               rst,
  input  epu_pkg::axi_addr_t awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,
  input  epu_pkg::data_t     wdata_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  output epu_pkg::resp_t     bresp_o,
  output logic               bvalid_o,
  input  logic               bready_i,
  input  epu_pkg::axi_addr_t araddr_i,
  input  logic               arvalid_i,
  output logic               arready_o,
  output epu_pkg::data_t     rdata_o,
  output epu_pkg::resp_t     rresp_o,
  output logic               rvalid_o,
  input  logic               rready_i,
  buf_port_if.master         host_port,
  input  logic               host_gnt_i,
  output logic               eng_start_o,
  output epu_pkg::count_t    eng_count_o,
  input  logic               eng_busy_i,
  input  logic               eng_done_i,
  input  epu_pkg::data_t     eng_result_i
);

  epu_pkg::slave_state_t state_q;
  epu_pkg::axi_addr_t    addr_q;
  epu_pkg::data_t        wdata_q;
  epu_pkg::resp_t        resp_q;
  epu_pkg::count_t       count_q;
  epu_pkg::data_t        reg_rdata;
  epu_pkg::resp_t        reg_resp;
  logic                  is_rd_q;
  logic                  is_buf;
  logic                  start_err;

  assign is_buf = (int'(addr_q) < `BUF_DEPTH * 4);
  assign start_err = !is_rd_q && (addr_q == `REG_CTRL) && wdata_q[`CTRL_START_BIT] && eng_busy_i;

  // register file read mux and response code
  always_comb begin
    reg_rdata = '0;
    reg_resp  = `RESP_OKAY;
    case (addr_q)
      `REG_CTRL:   reg_rdata = epu_pkg::data_t'({count_q, 8'h00});
      `REG_STATUS: reg_rdata = epu_pkg::data_t'({eng_done_i, eng_busy_i});
      `REG_RESULT: reg_rdata = eng_result_i;
      default:     reg_resp = `RESP_SLVERR;
    endcase
    if (start_err) begin
      reg_resp = `RESP_SLVERR;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q     <= epu_pkg::SL_IDLE;
      arready_o   <= 1'b0;
      awready_o   <= 1'b0;
      wready_o    <= 1'b0;
      bvalid_o    <= 1'b0;
      rvalid_o    <= 1'b0;
      eng_start_o <= 1'b0;
      count_q     <= '0;
    end else begin
      arready_o   <= 1'b0;
      awready_o   <= 1'b0;
      wready_o    <= 1'b0;
      eng_start_o <= 1'b0;
      case (state_q)
        epu_pkg::SL_IDLE: begin
          // reads win over writes
          if (arvalid_i) begin
            arready_o <= 1'b1;
            state_q   <= epu_pkg::SL_ADDR;
          end else if (awvalid_i && wvalid_i) begin
            awready_o <= 1'b1;
            wready_o  <= 1'b1;
            state_q   <= epu_pkg::SL_ADDR;
          end
        end
        epu_pkg::SL_ADDR: begin
          if (is_buf) begin
            state_q <= epu_pkg::SL_BUF;
          end else begin
            state_q <= epu_pkg::SL_REG;
            if (!is_rd_q && addr_q == `REG_CTRL && !start_err) begin
              count_q     <= wdata_q[`CTRL_CNT_LSB +: `BUF_AW];
              eng_start_o <= wdata_q[`CTRL_START_BIT];
            end
          end
        end
        epu_pkg::SL_BUF: begin
          // hold req until granted
          if (host_gnt_i) begin
            state_q <= epu_pkg::SL_BUF_DATA;
          end
        end
        epu_pkg::SL_REG, epu_pkg::SL_BUF_DATA: begin
          rvalid_o <= is_rd_q;
          bvalid_o <= !is_rd_q;
          state_q  <= epu_pkg::SL_RESP;
        end
        epu_pkg::SL_RESP: begin
          if ((rvalid_o && rready_i) || (bvalid_o && bready_i)) begin
            rvalid_o <= 1'b0;
            bvalid_o <= 1'b0;
            state_q  <= epu_pkg::SL_IDLE;
          end
        end
        default: state_q <= epu_pkg::SL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state_q)
      epu_pkg::SL_IDLE: begin
        if (arvalid_i) begin
          is_rd_q <= 1'b1;
          addr_q  <= araddr_i;
        end else if (awvalid_i && wvalid_i) begin
          is_rd_q <= 1'b0;
          addr_q  <= awaddr_i;
          wdata_q <= wdata_i;
        end
      end
      epu_pkg::SL_ADDR: begin
        if (!is_buf) begin
          resp_q  <= reg_resp;
          rdata_o <= reg_rdata;
        end
      end
      epu_pkg::SL_BUF_DATA: begin
        resp_q <= `RESP_OKAY;
        if (is_rd_q) begin
          rdata_o <= host_port.rdata;
        end
      end
      default: ;
    endcase
  end

  assign bresp_o = resp_q;
  assign rresp_o = resp_q;
  assign eng_count_o = count_q;

  // byte address to word index
  assign host_port.req   = (state_q == epu_pkg::SL_BUF);
  assign host_port.we    = !is_rd_q;
  assign host_port.addr  = addr_q[`BUF_AW+1:2];
  assign host_port.wdata = wdata_q;

endmodule

/* source/epu_top.sv */
`timescale 1ns/1ps

module epu_top (
  input  logic               clk,
  input  logic               rst,
  input  epu_pkg::axi_addr_t awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,
  input  epu_pkg::data_t     wdata_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  output epu_pkg::resp_t     bresp_o,
  output logic               bvalid_o,
  input  logic               bready_i,
  input  epu_pkg::axi_addr_t araddr_i,
  input  logic               arvalid_i,
  output logic               arready_o,
  output epu_pkg::data_t     rdata_o,
  output epu_pkg::resp_t     rresp_o,
  output logic               rvalid_o,
  input  logic               rready_i
);

  logic            host_gnt;
  logic            eng_start;
  logic            eng_busy;
  logic            eng_done;
  epu_pkg::count_t eng_count;
  epu_pkg::data_t  eng_result;

  buf_port_if host_port ();
  buf_port_if eng_port ();

  axi_lite_slave u_slave (
    .clk         (clk),
    .rst         (rst),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .host_port   (host_port),
    .host_gnt_i  (host_gnt),
    .eng_start_o (eng_start),
    .eng_count_o (eng_count),
    .eng_busy_i  (eng_busy),
    .eng_done_i  (eng_done),
    .eng_result_i(eng_result)
  );

  input_buffer u_buffer (
    .clk       (clk),
    .rst       (rst),
    .eng_busy_i(eng_busy),
    .host_port (host_port),
    .eng_port  (eng_port),
    .host_gnt_o(host_gnt)
  );

  accum_engine u_engine (
    .clk     (clk),
    .rst     (rst),
    .start_i (eng_start),
    .count_i (eng_count),
    .busy_o  (eng_busy),
    .done_o  (eng_done),
    .result_o(eng_result),
    .eng_port(eng_port)
  );

endmodule

/* verification/epu_asserts.sv */
`timescale 1ns/1ps

module epu_asserts (
  input logic clk,
  input logic rst,
  input logic host_gnt_i,
  input logic eng_gnt_i,
  input logic eng_busy_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic rvalid_i,
  input logic rready_i
);

  // one owner of the RAM per cycle
  a_one_grant: assert property (@(posedge clk) disable iff (rst)
    !(host_gnt_i && eng_gnt_i))
    else $error("host and engine granted in the same cycle");

  a_no_host_while_busy: assert property (@(posedge clk) disable iff (rst)
    host_gnt_i |-> !eng_busy_i)
    else $error("host granted while the engine is busy");

  // valid held until the handshake
  a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

endmodule

bind input_buffer epu_asserts u_arb_asserts (
  .clk       (clk),
  .rst       (rst),
  .host_gnt_i(host_gnt_o),
  .eng_gnt_i (eng_gnt),
  .eng_busy_i(eng_busy_i),
  .bvalid_i  (1'b0),
  .bready_i  (1'b0),
  .rvalid_i  (1'b0),
  .rready_i  (1'b0)
);

bind axi_lite_slave epu_asserts u_axi_asserts (
  .clk       (clk),
  .rst       (rst),
  .host_gnt_i(host_gnt_i),
  .eng_gnt_i (1'b0),
  .eng_busy_i(eng_busy_i),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i)
);

/* verification/epu_golden.txt */
# op addr data resp, hex; W write, R read and compare, P poll until data bits set
# F fills words from addr on with index in every byte, data is the word count
W 010 cafef00d 0
R 010 cafef00d 0
W 3fc 12345678 0
R 3fc 12345678 0
F 000 00000040 0
W 400 00000801 0
P 404 00000002 0
R 408 1c1c1c1c 0
R 020 1c1c1c1c 0
R 404 00000002 0
W 400 00004001 0
R 404 00000001 0
W 400 00000401 2
R 014 05050505 0
P 404 00000002 0
R 408 fbfbfbf4 0
R 100 fbfbfbf4 0
R 400 00004000 0
R 40c 00000000 2
W 800 00000000 2
W 000 deadbeef 0
W 400 00000001 0
P 404 00000002 0
R 408 00000000 0
R 000 00000000 0

/* verification/tb_epu_top.sv */
`timescale 1ns/1ps
`include "epu_consts.svh"

module tb_epu_top;

  logic               clk;
  logic               rst;
  epu_pkg::axi_addr_t awaddr;
  logic               awvalid;
  logic               awready;
  epu_pkg::data_t     wdata;
  logic               wvalid;
  logic               wready;
  epu_pkg::resp_t     bresp;
  logic               bvalid;
  logic               bready;
  epu_pkg::axi_addr_t araddr;
  logic               arvalid;
  logic               arready;
  epu_pkg::data_t     rdata;
  epu_pkg::resp_t     rresp;
  logic               rvalid;
  logic               rready;

  integer seed = 29279;
  integer errors = 0;
  integer checks = 0;
  integer cycles = 0;
  integer cycle_limit = 0;
  bit     golden_ok;

  // one entry per golden line
  logic [7:0]         gold_op[$];
  epu_pkg::axi_addr_t gold_addr[$];
  epu_pkg::data_t     gold_data[$];
  epu_pkg::resp_t     gold_resp[$];

  epu_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .awaddr_i (awaddr),
    .awvalid_i(awvalid),
    .awready_o(awready),
    .wdata_i  (wdata),
    .wvalid_i (wvalid),
    .wready_o (wready),
    .bresp_o  (bresp),
    .bvalid_o (bvalid),
    .bready_i (bready),
    .araddr_i (araddr),
    .arvalid_i(arvalid),
    .arready_o(arready),
    .rdata_o  (rdata),
    .rresp_o  (rresp),
    .rvalid_o (rvalid),
    .rready_i (rready)
  );

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: the DUT did not respond within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("[FAIL] %s: got %08h, expected %08h", name, actual, expected);
    end
  endtask

  // 0 to 3 idle cycles before a READY
  task automatic ready_delay;
    integer n;
    n = $unsigned($random(seed)) % 4;
    repeat (n) @(posedge clk);
  endtask

  task automatic axi_write(input epu_pkg::axi_addr_t addr, input epu_pkg::data_t data,
                           output epu_pkg::resp_t resp);
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_value("wready", 32'(wready), 32'(1'b1));
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    ready_delay();
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input epu_pkg::axi_addr_t addr, output epu_pkg::data_t data,
                          output epu_pkg::resp_t resp);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    ready_delay();
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic poll_status(input epu_pkg::axi_addr_t addr, input epu_pkg::data_t mask,
                             input epu_pkg::resp_t resp_exp);
    epu_pkg::data_t rd;
    epu_pkg::resp_t rs;
    axi_read(addr, rd, rs);
    while ((rd & mask) !== mask) begin
      axi_read(addr, rd, rs);
    end
    check_value($sformatf("rresp[%03h]", addr), 32'(rs), 32'(resp_exp));
  endtask

  // word i gets i in every byte
  task automatic fill_words(input epu_pkg::axi_addr_t start, input int count);
    epu_pkg::resp_t     rs;
    epu_pkg::buf_addr_t idx;
    idx = start[`BUF_AW+1:2];
    repeat (count) begin
      axi_write(epu_pkg::axi_addr_t'({idx, 2'b00}), {4{idx}}, rs);
      check_value("bresp", 32'(rs), 32'(`RESP_OKAY));
      idx = idx + 1'b1;
    end
  endtask

  task automatic load_golden(output bit ok);
    integer             fd;
    integer             n;
    logic [7:0]         tok;
    logic [8*128-1:0]   rest;
    epu_pkg::axi_addr_t a;
    epu_pkg::data_t     d;
    epu_pkg::resp_t     r;
    fd = $fopen("verification/epu_golden.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      n = $fscanf(fd, "%s", tok);
      while (n == 1) begin
        if (tok == "#") begin
          n = $fgets(rest, fd);
        end else begin
          n = $fscanf(fd, "%h %h %h", a, d, r);
          gold_op.push_back(tok);
          gold_addr.push_back(a);
          gold_data.push_back(d);
          gold_resp.push_back(r);
        end
        n = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
    end
  endtask

  task automatic run_golden;
    epu_pkg::data_t rd;
    epu_pkg::resp_t rs;
    for (int i = 0; i < gold_op.size(); i++) begin
      case (gold_op[i])
        "W": begin
          axi_write(gold_addr[i], gold_data[i], rs);
          check_value($sformatf("bresp[%03h]", gold_addr[i]), 32'(rs), 32'(gold_resp[i]));
        end
        "R": begin
          axi_read(gold_addr[i], rd, rs);
          check_value($sformatf("rdata[%03h]", gold_addr[i]), rd, gold_data[i]);
          check_value($sformatf("rresp[%03h]", gold_addr[i]), 32'(rs), 32'(gold_resp[i]));
        end
        "P": poll_status(gold_addr[i], gold_data[i], gold_resp[i]);
        "F": fill_words(gold_addr[i], int'(gold_data[i]));
        default: begin
          errors = errors + 1;
          $display("golden entry %0d has an unknown operation", i);
        end
      endcase
    end
  endtask

  initial begin
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    load_golden(golden_ok);
    if (!golden_ok) begin
      $display("could not open verification/epu_golden.txt");
      $display("Finished with errors");
      $finish;
    end else begin
      cycle_limit = 200 * gold_op.size();
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      run_golden();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Finished with no errors");
      end else begin
        $display("Finished with errors");
      end
      $finish;
    end
  end

endmodule
